/* common/sm83Pkg.sv */
// SM83 shared package with opcode constants, ALU and address-select types and the interrupt vector base.

package sm83Pkg;

	typedef enum logic [2:0] {
		aluAdd,		// 8-bit wrap-around add.
		aluSub,		// 8-bit wrap-around subtract.
		aluAnd,
		aluOr,
		aluXor,
		aluPass		// Operand straight through, used by LD A.
	} aluOpT;

	typedef enum logic [1:0] {
		addrPc,		// Program counter, for fetch and immediates.
		addrHl,		// HL pointer, for (HL) moves.
		addrTmp		// Jump target held in the operand temporary.
	} addrSelT;

	// Opcodes of the kept subset. Anything else runs as NOP.
	localparam logic [7:0] opNop     = 8'h00;
	localparam logic [7:0] opLdAImm  = 8'h3E;	// LD A,n.
	localparam logic [7:0] opLdHlImm = 8'h21;	// LD HL,nn.
	localparam logic [7:0] opLdAHl   = 8'h7E;	// LD A,(HL).
	localparam logic [7:0] opLdHlA   = 8'h77;	// LD (HL),A.
	localparam logic [7:0] opIncHl   = 8'h23;	// INC HL.
	localparam logic [7:0] opAddImm  = 8'hC6;	// ADD A,n.
	localparam logic [7:0] opSubImm  = 8'hD6;	// SUB A,n.
	localparam logic [7:0] opAndImm  = 8'hE6;	// AND A,n.
	localparam logic [7:0] opXorImm  = 8'hEE;	// XOR A,n.
	localparam logic [7:0] opOrImm   = 8'hF6;	// OR A,n.
	localparam logic [7:0] opJp      = 8'hC3;	// JP nn.
	localparam logic [7:0] opJpZ     = 8'hCA;	// JP Z,nn.
	localparam logic [7:0] opEi      = 8'hFB;
	localparam logic [7:0] opDi      = 8'hF3;
	localparam logic [7:0] opHalt    = 8'h76;

	// Line n vectors to this base plus 8 times n.
	localparam logic [15:0] irqVectorBase = 16'h0040;

endpackage

/* alu/sm83Alu.sv */
// SM83 8-bit ALU with add, subtract, logic ops, pass and zero detect.

`timescale 1ns/1ps

module sm83Alu import sm83Pkg::*; (
	input  aluOpT aluOp,
	input  logic [7:0] a,			// Accumulator.
	input  logic [7:0] operand,		// Latched memory byte.
	output logic [7:0] result,
	output logic zero
);

	always_comb begin
		case (aluOp)
			aluAdd:  result = a + operand;	// Carry out dropped.
			aluSub:  result = a - operand;	// Borrow dropped.
			aluAnd:  result = a & operand;
			aluOr:   result = a | operand;
			aluXor:  result = a ^ operand;
			default: result = operand;		// Pass for LD A.
		endcase
	end

	assign zero = (result == 8'h00);	// Z flag source.

endmodule

/* decoder/sm83Decoder.sv */
// SM83 decoder holding the instruction register and decoding each M-cycle's controls.

`timescale 1ns/1ps

module sm83Decoder import sm83Pkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  logic [7:0] dataIn,
	input  logic loadIR,
	input  logic [2:0] mCycle,
	input  logic zFlag,			// Only JP Z looks at it.
	output logic lastCycle,
	output logic memRead,
	output logic memWrite,
	output addrSelT addrSel,
	output logic loadA,
	output logic loadTmpLo,
	output logic loadTmpHi,
	output logic loadHlLo,
	output logic loadHlHi,
	output logic incHl,
	output logic loadPcFromTmp,
	output aluOpT aluOp,
	output logic aluEn,			// Flag-setting ALU op, updates Z.
	output logic imeSet,
	output logic imeClr,
	output logic haltReq
);

	logic [7:0] ir;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			ir <= opNop;
		else if (loadIR)
			ir <= dataIn;
	end

	always_comb begin
		lastCycle = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		addrSel = addrPc;	// Fetch and immediates read at PC.
		loadA = 1'b0;
		loadTmpLo = 1'b0;
		loadTmpHi = 1'b0;
		loadHlLo = 1'b0;
		loadHlHi = 1'b0;
		incHl = 1'b0;
		loadPcFromTmp = 1'b0;
		aluOp = aluPass;
		aluEn = 1'b0;
		imeSet = 1'b0;
		imeClr = 1'b0;
		haltReq = 1'b0;
		case (ir)
			opAddImm, opSubImm, opAndImm, opOrImm, opXorImm: begin
				case (ir)
					opAddImm: aluOp = aluAdd;
					opSubImm: aluOp = aluSub;
					opAndImm: aluOp = aluAnd;
					opOrImm:  aluOp = aluOr;
					default:  aluOp = aluXor;
				endcase
				if (mCycle == 3'd1) begin	// A op n into A.
					memRead = 1'b1;
					loadA = 1'b1;
					aluEn = 1'b1;
					lastCycle = 1'b1;
				end
			end
			opLdAImm, opLdAHl: begin
				if (mCycle == 3'd1) begin	// Loads go through the ALU as pass.
					memRead = 1'b1;
					addrSel = (ir == opLdAHl) ? addrHl : addrPc;
					loadA = 1'b1;
					lastCycle = 1'b1;
				end
			end
			opLdHlA: begin
				if (mCycle == 3'd1) begin
					memWrite = 1'b1;
					addrSel = addrHl;
					lastCycle = 1'b1;
				end
			end
			opIncHl: begin
				incHl = (mCycle == 3'd1);	// Internal cycle, no bus.
				lastCycle = (mCycle == 3'd1);
			end
			opLdHlImm: begin
				memRead = (mCycle != 3'd0);
				loadHlLo = (mCycle == 3'd1);	// Little-endian immediate.
				loadHlHi = (mCycle == 3'd2);
				lastCycle = (mCycle == 3'd2);
			end
			opJp, opJpZ: begin
				case (mCycle)
					3'd1: begin
						memRead = 1'b1;
						loadTmpLo = 1'b1;
					end
					3'd2: begin
						memRead = 1'b1;
						loadTmpHi = 1'b1;
						lastCycle = (ir == opJpZ) && !zFlag;	// Not taken, skip M3.
					end
					3'd3: begin
						addrSel = addrTmp;	// Target on the bus while PC loads.
						loadPcFromTmp = 1'b1;
						lastCycle = 1'b1;
					end
				endcase
			end
			default: begin	// NOP, EI, DI, HALT and unknowns finish in the fetch.
				lastCycle = 1'b1;
				imeSet = (ir == opEi);
				imeClr = (ir == opDi);
				haltReq = (ir == opHalt);
			end
		endcase
	end

endmodule

/* sequencer/sm83Sequencer.sv */
// SM83 sequencer with T-state and M-cycle counters, run/halt/dispatch state and bus strobes.

`timescale 1ns/1ps

module sm83Sequencer (
	input  logic CLK,
	input  logic rstN,
	input  logic lastCycle,		// Decoder marks the final M-cycle of the instruction.
	input  logic memRead,
	input  logic memWrite,
	input  logic haltReq,
	input  logic anyPending,	// Any request line pending, ignores IME.
	input  logic irqTake,		// Pending and enabled.
	output logic [1:0] tState,
	output logic [2:0] mCycle,
	output logic fetch,
	output logic loadIR,
	output logic rd,
	output logic wr,
	output logic dispatchDone,
	output logic latchData,		// Edge ending T2, read data is sampled.
	output logic commit			// Edge ending T3, registers update.
);

	typedef enum logic [1:0] {
		stRun,					// Fetch and execute.
		stHalt,					// Parked at T0, no strobes.
		stDispatch				// Two silent M-cycles before the vector jump.
	} seqStateT;

	seqStateT state;
	logic run;

	assign run = (state == stRun);
	assign fetch = run && (mCycle == 3'd0);	// M-cycle 0 of every instruction is the opcode fetch.
	assign rd = run && (tState == 2'd1 || tState == 2'd2) && (fetch || memRead);
	assign wr = run && !fetch && memWrite && (tState == 2'd2);
	assign loadIR = fetch && (tState == 2'd2);	// Opcode lands in ir on this edge.
	assign latchData = rd && (tState == 2'd2);
	assign commit = run && (tState == 2'd3);
	assign dispatchDone = (state == stDispatch) && (mCycle == 3'd1) && (tState == 2'd3);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= stRun;
			tState <= 2'd0;
			mCycle <= 3'd0;		// First fetch starts right after reset.
		end else begin
			case (state)
				stRun: begin
					tState <= tState + 2'd1;	// Wraps 3 to 0.
					if (tState == 2'd3) begin
						if (lastCycle) begin	// Instruction boundary.
							mCycle <= 3'd0;
							if (irqTake)
								state <= stDispatch;
							else if (haltReq)
								state <= stHalt;
						end else begin
							mCycle <= mCycle + 3'd1;
						end
					end
				end
				stHalt: begin
					// Wake on any pending line; with IME set it dispatches first.
					if (anyPending)
						state <= irqTake ? stDispatch : stRun;
				end
				default: begin	// Dispatch.
					tState <= tState + 2'd1;
					if (tState == 2'd3) begin
						if (mCycle == 3'd1) begin
							mCycle <= 3'd0;
							state <= stRun;		// Vector fetch follows at once.
						end else begin
							mCycle <= mCycle + 3'd1;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hdl/sm83RegFile.sv */
// SM83 register file with A, HL, PC, jump temporary, Z flag and bus address multiplexer.

`timescale 1ns/1ps

module sm83RegFile import sm83Pkg::*; #(
	parameter logic [15:0] resetVector = 16'h0000
) (
	input  logic CLK,
	input  logic rstN,
	input  logic [7:0] dataIn,
	input  logic latchData,
	input  logic commit,
	input  logic fetch,
	input  logic memRead,
	input  addrSelT addrSel,
	input  logic loadA,
	input  logic loadTmpLo,
	input  logic loadTmpHi,
	input  logic loadHlLo,
	input  logic loadHlHi,
	input  logic incHl,
	input  logic loadPcFromTmp,
	input  logic aluEn,
	input  logic [7:0] aluResult,
	input  logic aluZero,
	input  logic dispatchDone,
	input  logic [15:0] irqVector,
	output logic [15:0] addr,
	output logic [7:0] dataOut,
	output logic [7:0] aReg,
	output logic [7:0] operand,
	output logic zFlag
);

	logic [15:0] pc;
	logic [15:0] hl;
	logic [15:0] tmp;		// Jump target.
	logic pcInc;

	assign pcInc = fetch || (memRead && addrSel == addrPc);	// Every PC-addressed read.
	assign dataOut = aReg;	// Only LD (HL),A writes.

	always_comb begin
		case (addrSel)
			addrHl:  addr = hl;
			addrTmp: addr = tmp;
			default: addr = pc;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= resetVector;
			zFlag <= 1'b0;
		end else begin
			if (dispatchDone)
				pc <= irqVector;		// Interrupt entry, nothing pushed.
			else if (commit && loadPcFromTmp)
				pc <= tmp;
			else if (commit && pcInc)
				pc <= pc + 16'd1;
			if (commit && aluEn)
				zFlag <= aluZero;
		end
	end

	always_ff @(posedge CLK) begin
		if (latchData)
			operand <= dataIn;	// End of T2.
		if (commit) begin
			if (loadA)
				aReg <= aluResult;
			if (loadTmpLo)
				tmp[7:0] <= operand;
			if (loadTmpHi)
				tmp[15:8] <= operand;
			if (loadHlLo)
				hl[7:0] <= operand;
			if (loadHlHi)
				hl[15:8] <= operand;
			if (incHl)
				hl <= hl + 16'd1;
		end
	end

endmodule

/* hdl/sm83Interrupts.sv */
// SM83 interrupt unit with pending flags, IME, lowest-line priority select and acknowledge pulses.

`timescale 1ns/1ps

module sm83Interrupts import sm83Pkg::*; #(
	parameter int irqLines = 8
) (
	input  logic CLK,
	input  logic rstN,
	input  logic [irqLines-1:0] irqTrig,
	input  logic imeSet,
	input  logic imeClr,
	input  logic commit,
	input  logic dispatchDone,
	output logic anyPending,
	output logic irqTake,
	output logic [15:0] irqVector,
	output logic [irqLines-1:0] irqAck
);

	logic [irqLines-1:0] pending;
	logic [irqLines-1:0] selMask;	// One-hot lowest pending line.
	logic [7:0] selIdx;
	logic ime;

	always_comb begin
		selMask = '0;
		selIdx = 8'd0;
		for (int i = irqLines - 1; i >= 0; i--) begin	// Lowest index wins.
			if (pending[i]) begin
				selMask = '0;
				selMask[i] = 1'b1;
				selIdx = 8'(i);
			end
		end
	end

	assign irqVector = irqVectorBase + {5'd0, selIdx, 3'd0};	// Base plus 8 per line.
	assign anyPending = |pending;
	assign irqTake = anyPending && ime && !(commit && imeClr);	// DI takes effect at once.

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pending <= '0;
			ime <= 1'b0;
			irqAck <= '0;
		end else begin
			pending <= (pending & ~(dispatchDone ? selMask : '0)) | irqTrig;
			irqAck <= dispatchDone ? selMask : '0;	// One-clock pulse.
			if (dispatchDone)
				ime <= 1'b0;
			else if (commit && imeSet)
				ime <= 1'b1;
			else if (commit && imeClr)
				ime <= 1'b0;
		end
	end

endmodule

/* hdl/sm83Core.sv */
// SM83 core top level connecting sequencer, decoder, ALU, register file and interrupt unit.

`timescale 1ns/1ps

module sm83Core import sm83Pkg::*; #(
	parameter logic [15:0] resetVector = 16'h0000,	// First fetch address after reset.
	parameter int irqLines = 8						// Number of interrupt request lines.
) (
	input  logic CLK,
	input  logic rstN,
	input  logic [7:0] dataIn,					// Read data, valid at the end of T2.
	input  logic [irqLines-1:0] irqTrig,		// Interrupt request levels.
	output logic [15:0] addr,
	output logic [7:0] dataOut,
	output logic rd,
	output logic wr,
	output logic loadIR,						// Opcode-fetch marker, one clock per instruction.
	output logic [irqLines-1:0] irqAck
);

	logic [2:0] mCycle;
	logic fetch, latchData, commit, dispatchDone;
	logic lastCycle, memRead, memWrite, haltReq;
	logic anyPending, irqTake;
	logic loadA, loadTmpLo, loadTmpHi, loadHlLo, loadHlHi, incHl, loadPcFromTmp;
	logic aluEn, imeSet, imeClr, zFlag, aluZero;
	addrSelT addrSel;
	aluOpT aluOp;
	logic [7:0] aReg, operand, aluResult;
	logic [15:0] irqVector;

	sm83Sequencer seq (.CLK, .rstN, .lastCycle, .memRead, .memWrite, .haltReq, .anyPending,
		.irqTake, .tState(), .mCycle, .fetch, .loadIR, .rd, .wr, .dispatchDone, .latchData,
		.commit);

	sm83Decoder dec (.CLK, .rstN, .dataIn, .loadIR, .mCycle, .zFlag, .lastCycle, .memRead,
		.memWrite, .addrSel, .loadA, .loadTmpLo, .loadTmpHi, .loadHlLo, .loadHlHi, .incHl,
		.loadPcFromTmp, .aluOp, .aluEn, .imeSet, .imeClr, .haltReq);

	sm83Alu alu (.aluOp, .a(aReg), .operand, .result(aluResult), .zero(aluZero));

	sm83RegFile #(.resetVector(resetVector)) regs (.CLK, .rstN, .dataIn, .latchData,
		.commit, .fetch, .memRead, .addrSel, .loadA, .loadTmpLo, .loadTmpHi, .loadHlLo,
		.loadHlHi, .incHl, .loadPcFromTmp, .aluEn, .aluResult, .aluZero, .dispatchDone,
		.irqVector, .addr, .dataOut, .aReg, .operand, .zFlag);

	sm83Interrupts #(.irqLines(irqLines)) irq (.CLK, .rstN, .irqTrig, .imeSet, .imeClr,
		.commit, .dispatchDone, .anyPending, .irqTake, .irqVector, .irqAck);

endmodule

/* testbench/sm83CoreTb.sv */
// SM83 core testbench with clock, reset, memory model, xorshift source, check task and directed tests.

`timescale 1ns/1ps

module sm83CoreTb import sm83Pkg::*; ();

	localparam logic [15:0] bootAddr = 16'h0000;	// DUT default reset vector.
	localparam int unsigned timeoutCycles = 4000;	// Several times the summed test length.

	logic clk = 1'b0;
	logic rstN;
	logic [7:0] dataIn, dataOut, irqTrig, irqAck;
	logic [15:0] addr;
	logic rd, wr, loadIR;
	logic [7:0] mem [0:65535];
	logic [15:0] asmPtr;					// Assembler write pointer.
	logic [31:0] rngState = 32'h5d10_c5aa;
	int unsigned cycle = 0;
	int unsigned rdCount = 0;
	logic [15:0] fetchAddrQ[$];				// Address at every loadIR.
	int unsigned fetchCycQ[$];				// Cycle of every loadIR.
	logic [15:0] writeAddrQ[$];
	logic [7:0] writeDataQ[$];
	logic [7:0] ackQ[$];
	int fetchBase, writeBase, ackBase;		// Queue sizes when reset was last released.

	sm83Core DUT (.CLK(clk), .rstN, .dataIn, .irqTrig, .addr, .dataOut, .rd, .wr, .loadIR,
		.irqAck);

	always #2 clk = ~clk;

	assign dataIn = rd ? mem[addr] : 8'h00;	// Zero-wait responder.

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == timeoutCycles)
			abortRun($sformatf("TIMEOUT: run still going after %0d cycles", timeoutCycles));
	end

	// Bus monitor, sampled mid-cycle where outputs are settled.
	always @(negedge clk) begin
		if (!rstN) begin
			check("rd in reset", 32'(rd), 32'd0);
			check("wr in reset", 32'(wr), 32'd0);
			check("irqAck in reset", 32'(irqAck), 32'd0);
		end else begin
			if (loadIR) begin
				fetchAddrQ.push_back(addr);
				fetchCycQ.push_back(cycle);
			end
			if (wr) begin
				writeAddrQ.push_back(addr);
				writeDataQ.push_back(dataOut);
			end
			if (irqAck != '0)
				ackQ.push_back(irqAck);
			if (rd)
				rdCount <= rdCount + 1;
		end
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on error.");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected)
			abortRun($sformatf("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name,
				got, expected));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextRandom(output logic [7:0] value);
		rngState = xorshift32(rngState);
		value = rngState[7:0];
	endtask

	// Reference for the immediate ALU ops, 8-bit wrap.
	function automatic logic [7:0] aluModel(input logic [7:0] opcode, input logic [7:0] a,
		input logic [7:0] b);
		case (opcode)
			opAddImm: return a + b;
			opSubImm: return a - b;
			opAndImm: return a & b;
			opOrImm:  return a | b;
			default:  return a ^ b;
		endcase
	endfunction

	task automatic fillMemory();
		for (int a = 0; a < 65536; a++)
			mem[a[15:0]] = a[15:8] ^ a[7:0] ^ 8'hA5;	// Varies with every address bit.
	endtask

	task automatic emitOp(input logic [7:0] op);
		mem[asmPtr] = op;
		asmPtr = asmPtr + 16'd1;
	endtask

	task automatic emitImm(input logic [7:0] op, input logic [7:0] n);
		mem[asmPtr] = op;
		mem[asmPtr + 16'd1] = n;
		asmPtr = asmPtr + 16'd2;
	endtask

	task automatic emitWord(input logic [7:0] op, input logic [15:0] nn);
		mem[asmPtr] = op;
		mem[asmPtr + 16'd1] = nn[7:0];		// Little-endian.
		mem[asmPtr + 16'd2] = nn[15:8];
		asmPtr = asmPtr + 16'd3;
	endtask

	task automatic startRun();
		@(posedge clk);
		rstN <= 1'b0;
		irqTrig <= '0;
		repeat (10) @(posedge clk);
		fetchBase = fetchAddrQ.size();
		writeBase = writeAddrQ.size();
		ackBase = ackQ.size();
		rstN <= 1'b1;
	endtask

	task automatic pulseIrq(input logic [7:0] lines);
		@(posedge clk);
		irqTrig <= lines;
		@(posedge clk);
		irqTrig <= '0;
	endtask

	task automatic waitFetches(input int n);
		while (fetchAddrQ.size() < fetchBase + n)
			@(posedge clk);
	endtask

	task automatic waitWrites(input int n);
		while (writeAddrQ.size() < writeBase + n)
			@(posedge clk);
	endtask

	function automatic logic [15:0] fetchAddr(input int i);
		return fetchAddrQ[fetchBase + i];
	endfunction

	function automatic logic [31:0] fetchGap(input int i);
		return 32'(fetchCycQ[fetchBase + i + 1] - fetchCycQ[fetchBase + i]);
	endfunction

	task automatic testResetFetch();
		fillMemory();
		asmPtr = bootAddr;
		repeat (8) emitOp(opNop);
		startRun();
		waitFetches(6);
		check("addr at first loadIR", 32'(fetchAddr(0)), 32'(bootAddr));
		for (int i = 1; i < 6; i++) begin
			check("addr at loadIR", 32'(fetchAddr(i)), 32'(bootAddr + 16'(i)));
			check("loadIR spacing", fetchGap(i - 1), 32'd4);	// One M-cycle per NOP.
		end
		check("wr count", 32'(writeAddrQ.size() - writeBase), 32'd0);
	endtask

	task automatic testAluOps();
		logic [7:0] ops [0:4];
		logic [7:0] n1, n2, hi, lo;
		logic [15:0] target;
		ops = '{opAddImm, opSubImm, opAndImm, opOrImm, opXorImm};
		for (int k = 0; k < 5; k++) begin
			nextRandom(n1);
			nextRandom(n2);
			nextRandom(hi);
			nextRandom(lo);
			target = {hi | 8'h80, lo};		// Upper half, clear of the program.
			fillMemory();
			asmPtr = bootAddr;
			emitImm(opLdAImm, n1);
			emitImm(ops[k], n2);
			emitWord(opLdHlImm, target);
			emitOp(opLdHlA);
			emitOp(opHalt);
			startRun();
			waitWrites(1);
			check("addr at wr", 32'(writeAddrQ[writeBase]), 32'(target));
			check("dataOut at wr", 32'(writeDataQ[writeBase]), 32'(aluModel(ops[k], n1, n2)));
		end
	endtask

	task automatic testMemMove();
		logic [7:0] v, hi, lo;
		logic [15:0] src;
		int gaps [0:3];
		gaps = '{12, 8, 8, 8};		// LD HL,nn then three 2-M-cycle ops.
		nextRandom(v);
		nextRandom(hi);
		nextRandom(lo);
		src = {8'hA0 | (hi & 8'h0F), lo};
		fillMemory();
		mem[src] = v;
		asmPtr = bootAddr;
		emitWord(opLdHlImm, src);
		emitOp(opLdAHl);
		emitOp(opIncHl);
		emitOp(opLdHlA);
		emitOp(opHalt);
		startRun();
		waitFetches(5);
		waitWrites(1);
		check("addr at wr", 32'(writeAddrQ[writeBase]), 32'(src + 16'd1));
		check("dataOut at wr", 32'(writeDataQ[writeBase]), 32'(v));
		for (int i = 0; i < 4; i++)
			check("loadIR spacing", fetchGap(i), 32'(gaps[i]));
	endtask

	task automatic testJumps();
		logic [7:0] n1, n2;
		logic [15:0] expAddr [0:7];
		int gaps [0:6];
		nextRandom(n1);
		nextRandom(n2);
		n2 = n2 | 8'h01;			// OR result is never zero.
		fillMemory();
		asmPtr = bootAddr;
		emitWord(opJp, 16'h0123);
		asmPtr = 16'h0123;
		emitImm(opLdAImm, n1);
		emitImm(opSubImm, n1);		// Zero result sets Z.
		emitWord(opJpZ, 16'h0345);
		asmPtr = 16'h0345;
		emitImm(opLdAImm, n1);
		emitImm(opOrImm, n2);
		emitWord(opJpZ, 16'h0400);	// Target away from the fall-through byte.
		emitOp(opHalt);
		expAddr = '{bootAddr, 16'h0123, 16'h0125, 16'h0127, 16'h0345, 16'h0347, 16'h0349,
			16'h034C};
		gaps = '{16, 8, 8, 16, 8, 8, 12};	// Not-taken JP Z skips its last M-cycle.
		startRun();
		waitFetches(8);
		for (int i = 0; i < 8; i++)
			check("addr at loadIR", 32'(fetchAddr(i)), 32'(expAddr[i]));
		for (int i = 0; i < 7; i++)
			check("loadIR spacing", fetchGap(i), 32'(gaps[i]));
	endtask

	task automatic testInterrupts();
		fillMemory();
		asmPtr = bootAddr;
		emitOp(opDi);
		repeat (9) emitOp(opNop);
		emitOp(opEi);
		repeat (4) emitOp(opNop);
		asmPtr = irqVectorBase + 16'd16;	// Line 2 entry.
		emitOp(opEi);
		repeat (3) emitOp(opNop);
		asmPtr = irqVectorBase + 16'd40;	// Line 5 entry.
		emitOp(opHalt);
		startRun();
		waitFetches(2);
		pulseIrq(8'h20);
		waitFetches(7);
		check("irqAck count after DI", 32'(ackQ.size() - ackBase), 32'd0);
		pulseIrq(8'h04);
		waitFetches(15);
		check("irqAck count", 32'(ackQ.size() - ackBase), 32'd2);
		check("irqAck first", 32'(ackQ[ackBase]), 32'h04);
		check("irqAck second", 32'(ackQ[ackBase + 1]), 32'h20);
		check("addr at loadIR", 32'(fetchAddr(11)), 32'(bootAddr + 16'd11));
		check("loadIR spacing", fetchGap(11), 32'd12);	// NOP plus 2-M-cycle dispatch.
		check("addr at loadIR", 32'(fetchAddr(12)), 32'(irqVectorBase + 16'd16));
		check("addr at loadIR", 32'(fetchAddr(13)), 32'(irqVectorBase + 16'd17));
		check("addr at loadIR", 32'(fetchAddr(14)), 32'(irqVectorBase + 16'd40));
	endtask

	task automatic testHaltWake();
		int unsigned rdMark;
		fillMemory();
		asmPtr = bootAddr;
		emitOp(opNop);
		emitOp(opHalt);
		emitOp(opNop);
		emitOp(opNop);
		emitOp(opHalt);
		startRun();
		waitFetches(2);
		repeat (4) @(posedge clk);		// Let the HALT M-cycle finish.
		rdMark = rdCount;
		repeat (20) @(posedge clk);
		check("rd while halted", rdCount - rdMark, 32'd0);
		check("loadIR count while halted", 32'(fetchAddrQ.size() - fetchBase), 32'd2);
		pulseIrq(8'h02);
		waitFetches(4);
		check("addr at loadIR", 32'(fetchAddr(2)), 32'(bootAddr + 16'd2));
		check("addr at loadIR", 32'(fetchAddr(3)), 32'(bootAddr + 16'd3));
		check("irqAck count", 32'(ackQ.size() - ackBase), 32'd0);	// IME clear, wake only.
	endtask

	initial begin
		rstN = 1'b0;
		irqTrig = '0;
		asmPtr = bootAddr;
		testResetFetch();
		testAluOps();
		testMemMove();
		testJumps();
		testInterrupts();
		testHaltWake();
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* files.f */
common/sm83Pkg.sv
alu/sm83Alu.sv
decoder/sm83Decoder.sv
sequencer/sm83Sequencer.sv
hdl/sm83RegFile.sv
hdl/sm83Interrupts.sv
hdl/sm83Core.sv
testbench/sm83CoreTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = sm83CoreTb
FILELIST = files.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and scan the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Result: failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Result: no pass line in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
